//--- src.f
+incdir+.
sparcIsaPkg.sv
apbRegPkg.sv
instrDecoder.sv
aluExecute.sv
pipeRegBlock.sv
sparcExecPipe.sv
tbSparcPipe.sv

//--- run.sh
#!/bin/sh
# Compile and run the pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f src.f --top-module tbSparcPipe -o simv
./obj_dir/simv | tee sim.log
if grep -qx "Everything OK" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation reported failure"
    exit 1
fi

//--- tbRefModel.svh
// Reference model of decode, ALU and icc rules, included inside the pipeline testbench
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

function automatic decodedT decodeInstr(input wordT instr);
    decodedT    d;
    logic [5:0] op3;
    logic       listed;
    op3        = instr[24:19];
    listed     = 1'b1;
    d          = '0;
    d.aluOp    = aluAdd;                        // Anything unlisted adds
    d.rfEnable = 1'b1;
    d.wbSel    = wbAlu;
    d.rd       = instr[29:25];
    case (instr[31:30])
        2'b10: begin
            case (op3)
                6'h25: d.aluOp = aluSll;
                6'h26: d.aluOp = aluSrl;
                6'h27: d.aluOp = aluSra;
                6'h38: d.wbSel = wbPc;          // jumpl
                default: begin
                    case ({op3[5], op3[3:0]})   // cc bit ignored here
                        5'h00: d.aluOp = aluAdd;
                        5'h08: d.aluOp = aluAddx;
                        5'h04: d.aluOp = aluSub;
                        5'h0C: d.aluOp = aluSubx;
                        5'h01: d.aluOp = aluAnd;
                        5'h05: d.aluOp = aluAndn;
                        5'h02: d.aluOp = aluOr;
                        5'h06: d.aluOp = aluOrn;
                        5'h03: d.aluOp = aluXor;
                        5'h07: d.aluOp = aluXnor;
                        default: listed = 1'b0;
                    endcase
                    d.alterCc = listed && op3[4];
                end
            endcase
        end
        2'b00: begin
            if (instr[24:22] == 3'b100) begin
                d.aluOp = aluPassB;             // sethi
            end else if (instr[24:22] == 3'b010) begin
                d.rfEnable = 1'b0;              // Branch
            end
        end
        2'b01: d.wbSel = wbPc;                  // call
        default: begin
            case (op3)
                6'h09: d.memCtl = '{1'b1, 1'b0, 1'b1, sizeByte};
                6'h0A: d.memCtl = '{1'b1, 1'b0, 1'b1, sizeHalf};
                6'h00, 6'h03: d.memCtl = '{1'b1, 1'b0, 1'b0, sizeWord};
                6'h01, 6'h0D: d.memCtl = '{1'b1, 1'b0, 1'b0, sizeByte};
                6'h02: d.memCtl = '{1'b1, 1'b0, 1'b0, sizeHalf};
                6'h05: d.memCtl = '{1'b1, 1'b1, 1'b0, sizeByte};
                6'h06: d.memCtl = '{1'b1, 1'b1, 1'b0, sizeHalf};
                6'h04, 6'h07: d.memCtl = '{1'b1, 1'b1, 1'b0, sizeWord};
                default: ;
            endcase
            if (d.memCtl.enable) begin
                d.wbSel    = d.memCtl.rw ? wbAlu : wbMem;
                d.rfEnable = !d.memCtl.rw;      // Stores write nothing
            end
        end
    endcase
    return d;
endfunction

function automatic wordT computeAlu(input aluOpE op, input wordT a, input wordT b, input logic cin);
    case (op)
        aluAdd:   return a + b;
        aluAddx:  return a + b + 32'(cin);
        aluSub:   return a - b;
        aluSubx:  return a - b - 32'(cin);
        aluAnd:   return a & b;
        aluOr:    return a | b;
        aluXor:   return a ^ b;
        aluXnor:  return ~(a ^ b);
        aluAndn:  return a & ~b;
        aluOrn:   return a | ~b;
        aluSll:   return a << b[4:0];
        aluSrl:   return a >> b[4:0];
        aluSra:   return wordT'($signed(a) >>> b[4:0]);
        aluPassA: return a;
        aluPassB: return b;
        default:  return ~b;                    // aluNotB
    endcase
endfunction

function automatic iccT nextIcc(input aluOpE op, input wordT a, input wordT b, input iccT cur);
    wordT        r;
    logic [32:0] wide;
    iccT         f;
    r = computeAlu(op, a, b, cur.c);
    f = cur;
    if (op <= aluOrn) begin
        f = '{r[31], (r == 32'd0), 1'b0, 1'b0};  // Logic ops clear v and c
    end
    case (op)
        aluAdd, aluAddx: begin
            wide = {1'b0, a} + {1'b0, b} + 33'(op == aluAddx && cur.c);
            f.c  = wide[32];
            f.v  = (a[31] == b[31]) && (r[31] != a[31]);
        end
        aluSub, aluSubx: begin
            wide = {1'b0, a} - {1'b0, b} - 33'(op == aluSubx && cur.c);
            f.c  = wide[32];                    // Borrow
            f.v  = (a[31] != b[31]) && (r[31] != a[31]);
        end
        default: ;
    endcase
    return f;
endfunction

`endif

//--- tbSparcPipe.sv
// Testbench for the execute pipeline: random instructions and APB traffic checked against a model
`timescale 1ns/1ns

module tbSparcPipe import sparcIsaPkg::*, apbRegPkg::*; ();

    localparam int numAlu       = 300;
    localparam int ccRounds     = 4;
    localparam int ccPerRound   = 50;
    localparam int numMem       = 100;
    localparam int apbRounds    = 8;
    localparam int apbBudget    = 40;           // Upper bound of register accesses
    localparam int timeoutLimit =
        (numAlu + ccRounds * ccPerRound + numMem + apbRounds + apbBudget) * 4 + 100;

    logic   Clk;
    logic   arstN;
    issueT  issue;
    logic   issueVld;
    logic   issueRdy;
    resultT result;
    logic   resVld;
    apbReqT apbReq;
    apbRspT apbRsp;

    resultT expQ[$];                            // Expected results in issue order
    int     edgeQ[$];                           // Acceptance edge of each
    iccT    modelIcc = '0;
    int     cycleCnt = 0;
    int     resultsSeen = 0;
    int     valueErrs = 0;
    int     otherErrs = 0;

    `include "tbRefModel.svh"

    sparcExecPipe #(
        .apbAddrWidth (8)
    ) DUT (
        .Clk      (Clk),
        .arstN    (arstN),
        .issue    (issue),
        .issueVld (issueVld),
        .issueRdy (issueRdy),
        .result   (result),
        .resVld   (resVld),
        .apbReq   (apbReq),
        .apbRsp   (apbRsp)
    );

    initial begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;                  // 10 ns period
    end

    always @(posedge Clk) cycleCnt <= cycleCnt + 1;

    task automatic checkVal(input string name, input logic [31:0] expVal,
                            input logic [31:0] actVal);
        assert (actVal === expVal) else begin
            valueErrs++;
            $display("Error at %0t ns: %s expected 0x%08h, got 0x%08h",
                     $time, name, expVal, actVal);
        end
    endtask

    // One APB transfer, called on a falling edge
    task automatic busAccess(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic err);
        apbReq.psel    = 1'b1;                  // Setup phase
        apbReq.penable = 1'b0;
        apbReq.pwrite  = wr;
        apbReq.paddr   = addr;
        apbReq.pwdata  = wdata;
        @(negedge Clk);
        apbReq.penable = 1'b1;                  // Access phase
        @(negedge Clk);
        rdata  = apbRsp.prdata;
        err    = apbRsp.pslverr;
        checkVal("pready", 32'd1, 32'(apbRsp.pready));
        apbReq = '0;
    endtask

    task automatic writeReg(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        busAccess(1'b1, addr, data, rdata, err);
    endtask

    task automatic expectReg(input logic [7:0] addr, input logic [31:0] expVal,
                             input string name);
        logic [31:0] rdata;
        logic        err;
        busAccess(1'b0, addr, 32'd0, rdata, err);
        checkVal(name, expVal, rdata);
        checkVal({name, " pslverr"}, 32'd0, 32'(err));
    endtask

    // Holds the word until accepted, then updates the model
    task automatic issueInstr(input wordT instr, input wordT a, input wordT b, input int gap);
        decodedT d;
        resultT  expRes;
        issue.instr = instr;
        issue.opA   = a;
        issue.opB   = b;
        issueVld    = 1'b1;
        while (!issueRdy) @(negedge Clk);
        d               = decodeInstr(instr);
        expRes.result   = computeAlu(d.aluOp, a, b, modelIcc.c);
        expRes.rd       = d.rd;
        expRes.rfEnable = d.rfEnable;
        expRes.memCtl   = d.memCtl;
        expRes.wbSel    = d.wbSel;
        if (d.alterCc) begin
            modelIcc = nextIcc(d.aluOp, a, b, modelIcc);
        end
        expQ.push_back(expRes);
        edgeQ.push_back(cycleCnt + 1);          // Taken at the coming edge
        @(negedge Clk);
        issueVld = 1'b0;
        repeat (gap) @(negedge Clk);
    endtask

    task automatic drainPipe();
        while (expQ.size() != 0) @(negedge Clk);
        @(negedge Clk);
    endtask

    // Arithmetic, logic, shift or sethi word, maxPick limits the op choice
    function automatic wordT arithWord(input int ccPct, input int maxPick);
        int         pick;
        logic [5:0] op3;
        pick = int'($urandom_range(maxPick, 0));
        if (pick == 13) begin
            return {2'b00, 5'($urandom), 3'b100, 22'($urandom)};
        end
        case (pick)
            0: op3 = 6'h00;
            1: op3 = 6'h08;
            2: op3 = 6'h04;
            3: op3 = 6'h0C;
            4: op3 = 6'h01;
            5: op3 = 6'h05;
            6: op3 = 6'h02;
            7: op3 = 6'h06;
            8: op3 = 6'h03;
            9: op3 = 6'h07;
            10: op3 = 6'h25;
            11: op3 = 6'h26;
            default: op3 = 6'h27;
        endcase
        if (pick < 10 && int'($urandom_range(99, 0)) < ccPct) begin
            op3[4] = 1'b1;                      // cc variant
        end
        return {2'b10, 5'($urandom), op3, 19'($urandom)};
    endfunction

    function automatic wordT memWord();
        logic [5:0] op3;
        case ($urandom_range(10, 0))
            0: op3 = 6'h09;
            1: op3 = 6'h0A;
            2: op3 = 6'h00;
            3: op3 = 6'h01;
            4: op3 = 6'h02;
            5: op3 = 6'h03;
            6: op3 = 6'h0D;
            7: op3 = 6'h05;
            8: op3 = 6'h06;
            9: op3 = 6'h04;
            default: op3 = 6'h07;
        endcase
        return {2'b11, 5'($urandom), op3, 19'($urandom)};
    endfunction

    // sethi carries its shifted immediate, others sometimes repeat A for z
    function automatic wordT pickOpB(input wordT instr, input wordT a);
        if (instr[31:30] == 2'b00) begin
            return {instr[21:0], 10'b0};
        end
        return ($urandom_range(3, 0) == 0) ? a : $urandom;
    endfunction

    always @(negedge Clk) begin : monitor
        resultT expRes;
        int     edgeAt;
        if (arstN && resVld) begin
            assert (expQ.size() != 0) else begin
                otherErrs++;
                $display("Result delivered at %0t ns with no instruction outstanding", $time);
            end
            if (expQ.size() != 0) begin
                expRes = expQ.pop_front();
                edgeAt = edgeQ.pop_front();
                checkVal("result.result", expRes.result, result.result);
                checkVal("result.rd", 32'(expRes.rd), 32'(result.rd));
                checkVal("result.rfEnable", 32'(expRes.rfEnable), 32'(result.rfEnable));
                checkVal("result.memCtl", 32'(expRes.memCtl), 32'(result.memCtl));
                checkVal("result.wbSel", 32'(expRes.wbSel), 32'(result.wbSel));
                checkVal("resVld cycle", 32'(edgeAt + 1), 32'(cycleCnt));
            end
            resultsSeen++;
        end
    end

    initial begin : watchdog
        wait (cycleCnt >= timeoutLimit);
        $display("Timeout: run stopped after %0d cycles", cycleCnt);
        $display("Something failed");
        $finish;
    end

    initial begin : stimulus
        wordT        instr;
        wordT        a;
        logic [31:0] rdata;
        logic        err;
        iccT         forced;
        void'($urandom(39));
        arstN    = 1'b0;
        issue    = '0;
        issueVld = 1'b0;
        apbReq   = '0;
        repeat (4) @(negedge Clk);
        arstN = 1'b1;
        @(negedge Clk);
        checkVal("issueRdy", 32'd0, 32'(issueRdy));
        checkVal("resVld", 32'd0, 32'(resVld));
        expectReg(regCtrl, 32'd0, "CTRL");
        expectReg(regIcc, 32'd0, "ICC");
        expectReg(regRetired, 32'd0, "RETIRED");
        writeReg(regCtrl, 32'd1);               // Start the pipeline
        checkVal("issueRdy", 32'd1, 32'(issueRdy));

        for (int i = 0; i < numAlu; i++) begin
            instr = arithWord(30, 13);
            a     = $urandom;
            issueInstr(instr, a, pickOpB(instr, a), int'($urandom_range(2, 0)));
        end
        drainPipe();

        for (int r = 0; r < ccRounds; r++) begin
            for (int i = 0; i < ccPerRound; i++) begin
                instr = arithWord(60, ($urandom_range(1, 0) == 0) ? 3 : 9);
                a     = $urandom;
                issueInstr(instr, a, pickOpB(instr, a), int'($urandom_range(1, 0)));
            end
            drainPipe();
            expectReg(regIcc, 32'(modelIcc), "ICC");
        end

        for (int i = 0; i < numMem; i++) begin
            issueInstr(memWord(), $urandom, $urandom, int'($urandom_range(2, 0)));
        end
        drainPipe();

        writeReg(regCtrl, 32'd0);               // Stall
        issue.instr = arithWord(0, 13);
        issueVld    = 1'b1;
        repeat (20) begin
            @(negedge Clk);
            checkVal("resVld", 32'd0, 32'(resVld));
            checkVal("issueRdy", 32'd0, 32'(issueRdy));
        end
        issueVld = 1'b0;
        expectReg(regRetired, 32'(numAlu + ccRounds * ccPerRound + numMem), "RETIRED");
        writeReg(regRetired, $urandom);         // Any write clears
        expectReg(regRetired, 32'd0, "RETIRED");
        writeReg(regCtrl, 32'd1);

        for (int r = 0; r < apbRounds; r++) begin
            forced = iccT'(4'($urandom));
            writeReg(regIcc, 32'(forced));
            modelIcc = forced;
            instr    = {2'b10, 5'($urandom), 1'b0, 1'($urandom), 4'h8, 19'($urandom)};
            issueInstr(instr, $urandom, $urandom, 0);   // addx or addxcc
            drainPipe();
            expectReg(regIcc, 32'(modelIcc), "ICC");
        end

        busAccess(1'b0, 8'h0C, 32'd0, rdata, err);
        checkVal("prdata at 0xC", 32'd0, rdata);
        checkVal("pslverr at 0xC", 32'd1, 32'(err));
        busAccess(1'b1, 8'h0C, $urandom, rdata, err);
        checkVal("pslverr at 0xC", 32'd1, 32'(err));
        expectReg(regCtrl, 32'd1, "CTRL");
        expectReg(regRetired, 32'(apbRounds), "RETIRED");

        assert (expQ.size() == 0) else begin
            otherErrs++;
            $display("%0d expected results never arrived", expQ.size());
        end
        $display("Results seen %0d, value errors %0d, other errors %0d",
                 resultsSeen, valueErrs, otherErrs);
        if (valueErrs + otherErrs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- sparcExecPipe.sv
// Top of the SPARC integer execute path: decode, ALU stage and APB control block
`timescale 1ns/1ns

module sparcExecPipe import sparcIsaPkg::*, apbRegPkg::*; #(
    parameter int apbAddrWidth = 8
) (
    input  logic   Clk,
    input  logic   arstN,
    input  issueT  issue,
    input  logic   issueVld,
    output logic   issueRdy,
    output resultT result,
    output logic   resVld,
    input  apbReqT apbReq,
    output apbRspT apbRsp
);

    decodedT dec;
    wordT    opA;
    wordT    opB;
    logic    decVld;
    logic    run;
    logic    carry;
    iccT     iccNext;
    logic    iccWrEn;
    logic    retire;

    assign issueRdy = run;                      // Stall only through run

    instrDecoder uDecoder (
        .Clk      (Clk),
        .arstN    (arstN),
        .issue    (issue),
        .issueVld (issueVld),
        .run      (run),
        .dec      (dec),
        .opA      (opA),
        .opB      (opB),
        .decVld   (decVld)
    );

    aluExecute uExecute (
        .Clk      (Clk),
        .arstN    (arstN),
        .dec      (dec),
        .opA      (opA),
        .opB      (opB),
        .decVld   (decVld),
        .carryIn  (carry),
        .iccNext  (iccNext),
        .iccWrEn  (iccWrEn),
        .retire   (retire),
        .result   (result),
        .resVld   (resVld)
    );

    pipeRegBlock #(
        .apbAddrWidth (apbAddrWidth)
    ) uRegBlock (
        .Clk      (Clk),
        .arstN    (arstN),
        .apbReq   (apbReq),
        .apbRsp   (apbRsp),
        .iccWrEn  (iccWrEn),
        .iccNext  (iccNext),
        .retire   (retire),
        .run      (run),
        .carryOut (carry)
    );

endmodule

//--- pipeRegBlock.sv
// APB register block beside the pipeline: run control, icc and retired count
`timescale 1ns/1ns

module pipeRegBlock import apbRegPkg::*; #(
    parameter int apbAddrWidth = 8              // Decoded offset bits
) (
    input  logic   Clk,
    input  logic   arstN,
    input  apbReqT apbReq,
    output apbRspT apbRsp,
    input  logic   iccWrEn,
    input  iccT    iccNext,
    input  logic   retire,
    output logic   run,
    output logic   carryOut
);

    logic [apbAddrWidth-1:0] offset;
    logic                    access;
    logic                    wrAccess;
    logic                    hitCtrl;
    logic                    hitIcc;
    logic                    hitRetired;
    iccT                     icc;
    logic [31:0]             retired;

    assign offset     = apbReq.paddr[apbAddrWidth-1:0];
    assign access     = apbReq.psel && apbReq.penable;     // Access phase
    assign wrAccess   = access && apbReq.pwrite;
    assign hitCtrl    = (offset == apbAddrWidth'(regCtrl));
    assign hitIcc     = (offset == apbAddrWidth'(regIcc));
    assign hitRetired = (offset == apbAddrWidth'(regRetired));

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            run     <= 1'b0;
            icc     <= '0;
            retired <= '0;
        end else begin
            if (wrAccess && hitCtrl) begin
                run <= apbReq.pwdata[0];
            end
            if (wrAccess && hitIcc) begin
                icc <= iccT'(apbReq.pwdata[3:0]);   // Bus write beats pipeline
            end else if (iccWrEn) begin
                icc <= iccNext;
            end
            if (wrAccess && hitRetired) begin
                retired <= '0;                      // Clear beats increment
            end else if (retire) begin
                retired <= retired + 32'd1;
            end
        end
    end

    always_comb begin
        apbRsp         = '0;
        apbRsp.pready  = 1'b1;                      // Zero wait states
        apbRsp.pslverr = access && !(hitCtrl || hitIcc || hitRetired);
        if (access && !apbReq.pwrite) begin
            if (hitCtrl) begin
                apbRsp.prdata = {31'b0, run};
            end else if (hitIcc) begin
                apbRsp.prdata = {28'b0, icc};
            end else if (hitRetired) begin
                apbRsp.prdata = retired;
            end
        end
    end

    assign carryOut = icc.c;                        // Feeds addx and subx

    aEnableNeedsSel: assert property (@(posedge Clk) disable iff (!arstN)
        apbReq.penable |-> apbReq.psel);

    // Address set in setup must hold into access
    aAddrStable: assert property (@(posedge Clk) disable iff (!arstN)
        apbReq.psel && !apbReq.penable |=> $stable(apbReq.paddr));

endmodule

//--- aluExecute.sv
// Execute stage: ALU with icc flag generation and the result register
`timescale 1ns/1ns

module aluExecute import sparcIsaPkg::*, apbRegPkg::*; (
    input  logic    Clk,
    input  logic    arstN,
    input  decodedT dec,
    input  wordT    opA,
    input  wordT    opB,
    input  logic    decVld,
    input  logic    carryIn,
    output iccT     iccNext,
    output logic    iccWrEn,
    output logic    retire,
    output resultT  result,
    output logic    resVld
);

    logic [32:0] sum;                           // Carry or borrow in bit 32
    wordT        aluOut;
    logic        addGrp;
    logic        subGrp;

    assign addGrp = (dec.aluOp == aluAdd) || (dec.aluOp == aluAddx);
    assign subGrp = (dec.aluOp == aluSub) || (dec.aluOp == aluSubx);

    always_comb begin
        sum    = '0;
        aluOut = '0;
        case (dec.aluOp)
            aluAdd:   sum = {1'b0, opA} + {1'b0, opB};
            aluAddx:  sum = {1'b0, opA} + {1'b0, opB} + {32'b0, carryIn};
            aluSub:   sum = {1'b0, opA} - {1'b0, opB};
            aluSubx:  sum = {1'b0, opA} - {1'b0, opB} - {32'b0, carryIn};
            aluAnd:   aluOut = opA & opB;
            aluOr:    aluOut = opA | opB;
            aluXor:   aluOut = opA ^ opB;
            aluXnor:  aluOut = ~(opA ^ opB);
            aluAndn:  aluOut = opA & ~opB;
            aluOrn:   aluOut = opA | ~opB;
            aluSll:   aluOut = opA << opB[4:0];
            aluSrl:   aluOut = opA >> opB[4:0];
            aluSra:   aluOut = wordT'($signed(opA) >>> opB[4:0]);
            aluPassA: aluOut = opA;
            aluPassB: aluOut = opB;
            aluNotB:  aluOut = ~opB;
            default:  aluOut = '0;
        endcase
        if (addGrp || subGrp) begin
            aluOut = sum[31:0];
        end
    end

    // Flags, only written for cc variants of ops 0 to 9
    always_comb begin
        iccNext   = '0;
        iccNext.c = carryIn;                    // Carry held outside add/sub/logic
        if (dec.aluOp <= aluOrn) begin
            iccNext.n = aluOut[31];
            iccNext.z = (aluOut == '0);
            iccNext.c = sum[32];                // Zero for logic ops
        end
        if (addGrp) begin
            iccNext.v = (opA[31] == opB[31]) && (aluOut[31] != opA[31]);
        end else if (subGrp) begin
            iccNext.v = (opA[31] != opB[31]) && (aluOut[31] != opA[31]);
        end
    end

    assign iccWrEn = decVld && dec.alterCc;     // Lands with the result edge
    assign retire  = decVld;                    // One pulse per instruction

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            resVld <= 1'b0;
        end else begin
            resVld <= decVld;
        end
    end

    always_ff @(posedge Clk) begin
        if (decVld) begin
            result.result   <= aluOut;
            result.rd       <= dec.rd;
            result.rfEnable <= dec.rfEnable;
            result.memCtl   <= dec.memCtl;
            result.wbSel    <= dec.wbSel;
        end
    end

    // Flag logic only covers add..orn
    aCcOpRange: assert property (@(posedge Clk) disable iff (!arstN)
        decVld && dec.alterCc |-> dec.aluOp <= aluOrn);

    // A delivered result never carries X from operands or decode
    aResultKnown: assert property (@(posedge Clk) disable iff (!arstN)
        resVld |-> !$isunknown(result));

endmodule

//--- instrDecoder.sv
// Decode stage: turns an issued SPARC word into control fields and registers them
`timescale 1ns/1ns

module instrDecoder import sparcIsaPkg::*; (
    input  logic    Clk,
    input  logic    arstN,
    input  issueT   issue,
    input  logic    issueVld,
    input  logic    run,
    output decodedT dec,
    output wordT    opA,
    output wordT    opB,
    output logic    decVld
);

    opClassE    op;
    logic [5:0] op3;
    logic [2:0] op2;
    logic       xfer;
    logic       ccCapable;                      // Listed add/sub/logic encoding
    decodedT    decNext;

    assign op   = opClassE'(issue.instr[31:30]);
    assign op3  = issue.instr[24:19];
    assign op2  = issue.instr[24:22];
    assign xfer = issueVld && run;              // Issue handshake

    always_comb begin
        decNext          = '0;
        decNext.aluOp    = aluAdd;              // Unlisted encodings add
        decNext.rfEnable = 1'b1;
        decNext.wbSel    = wbAlu;
        decNext.rd       = issue.instr[29:25];
        ccCapable        = 1'b0;
        case (op)
            opArith: begin
                if (!op3[5]) begin
                    ccCapable = 1'b1;
                    case (op3[3:0])             // op3 bit 4 picks the cc variant
                        4'h0: decNext.aluOp = aluAdd;
                        4'h8: decNext.aluOp = aluAddx;
                        4'h4: decNext.aluOp = aluSub;
                        4'hC: decNext.aluOp = aluSubx;
                        4'h1: decNext.aluOp = aluAnd;
                        4'h5: decNext.aluOp = aluAndn;
                        4'h2: decNext.aluOp = aluOr;
                        4'h6: decNext.aluOp = aluOrn;
                        4'h3: decNext.aluOp = aluXor;
                        4'h7: decNext.aluOp = aluXnor;
                        default: ccCapable = 1'b0;
                    endcase
                    decNext.alterCc = op3[4] && ccCapable;
                end else begin
                    case (op3)
                        6'h25: decNext.aluOp = aluSll;
                        6'h26: decNext.aluOp = aluSrl;
                        6'h27: decNext.aluOp = aluSra;
                        6'h38: decNext.wbSel = wbPc;    // jumpl, target from A + B
                        default: ;
                    endcase
                end
            end
            opBranch: begin
                if (op2 == 3'b100) begin
                    decNext.aluOp = aluPassB;   // sethi, immediate already in B
                end else if (op2 == 3'b010) begin
                    decNext.rfEnable = 1'b0;    // Bicc writes nothing
                end
            end
            opCall: decNext.wbSel = wbPc;       // Return address write-back
            opMem: begin
                decNext.memCtl.enable = 1'b1;
                case (op3)
                    6'h09: begin                // ldsb
                        decNext.memCtl.signExt = 1'b1;
                        decNext.memCtl.size    = sizeByte;
                    end
                    6'h0A: begin                // ldsh
                        decNext.memCtl.signExt = 1'b1;
                        decNext.memCtl.size    = sizeHalf;
                    end
                    6'h00, 6'h03: decNext.memCtl.size = sizeWord;   // ld, ldd
                    6'h01, 6'h0D: decNext.memCtl.size = sizeByte;   // ldub, ldstub
                    6'h02:        decNext.memCtl.size = sizeHalf;   // lduh
                    6'h05: decNext.memCtl = '{1'b1, 1'b1, 1'b0, sizeByte};  // stb
                    6'h06: decNext.memCtl = '{1'b1, 1'b1, 1'b0, sizeHalf};  // sth
                    6'h04, 6'h07: decNext.memCtl = '{1'b1, 1'b1, 1'b0, sizeWord};
                    default: decNext.memCtl = '0;   // Not a memory op
                endcase
                if (decNext.memCtl.enable && !decNext.memCtl.rw) begin
                    decNext.wbSel = wbMem;      // Loads return memory data
                end
                if (decNext.memCtl.rw) begin
                    decNext.rfEnable = 1'b0;    // Stores write no register
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            decVld <= 1'b0;
        end else begin
            decVld <= xfer;                     // Bubble when nothing accepted
        end
    end

    always_ff @(posedge Clk) begin
        if (xfer) begin
            dec <= decNext;
            opA <= issue.opA;
            opB <= issue.opB;
        end
    end

    // Issue word held while stalled
    aIssueHeld: assert property (@(posedge Clk) disable iff (!arstN)
        issueVld && !run |=> !issueVld || $stable(issue));

endmodule

//--- apbRegPkg.sv
// APB bus and register map types for the pipeline control block and its users
package apbRegPkg;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;                     // Byte offset
        logic [31:0] pwdata;
    } apbReqT;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;                    // Tied high, zero wait
        logic        pslverr;                   // Unmapped offset
    } apbRspT;

    typedef struct packed {
        logic n;                                // Negative
        logic z;                                // Zero
        logic v;                                // Signed overflow
        logic c;                                // Carry or borrow
    } iccT;

    typedef enum logic [7:0] {
        regCtrl    = 8'h00,                     // Bit 0 is run
        regIcc     = 8'h04,                     // n z v c in bits 3:0
        regRetired = 8'h08                      // Write clears
    } regAddrE;

endpackage

//--- sparcIsaPkg.sv
// ISA types for the SPARC execute path, imported by decoder, ALU and top level
package sparcIsaPkg;

    typedef logic [31:0] wordT;                 // Data word
    typedef logic [4:0]  regIdxT;               // Destination register index

    typedef enum logic [3:0] {
        aluAdd   = 4'd0,                        // A + B
        aluAddx  = 4'd1,                        // A + B + carry
        aluSub   = 4'd2,                        // A - B
        aluSubx  = 4'd3,                        // A - B - carry
        aluAnd   = 4'd4,
        aluOr    = 4'd5,
        aluXor   = 4'd6,
        aluXnor  = 4'd7,
        aluAndn  = 4'd8,                        // A & ~B
        aluOrn   = 4'd9,                        // A | ~B
        aluSll   = 4'd10,
        aluSrl   = 4'd11,
        aluSra   = 4'd12,                       // Sign kept on right shift
        aluPassA = 4'd13,
        aluPassB = 4'd14,                       // Used by sethi
        aluNotB  = 4'd15
    } aluOpE;

    typedef enum logic [1:0] {
        opBranch = 2'd0,                        // Branch and sethi
        opCall   = 2'd1,
        opArith  = 2'd2,                        // Arithmetic, logic, shifts, jumpl
        opMem    = 2'd3                         // Loads and stores
    } opClassE;

    typedef enum logic [1:0] {
        sizeByte = 2'd0,
        sizeHalf = 2'd1,
        sizeWord = 2'd2
    } memSizeE;

    typedef enum logic [1:0] {
        wbPc  = 2'd0,                           // Call and jumpl return address
        wbAlu = 2'd1,
        wbMem = 2'd3                            // Load data
    } wbSelE;

    typedef struct packed {
        logic    enable;                        // Memory access present
        logic    rw;                            // 1 for store
        logic    signExt;                       // ldsb, ldsh
        memSizeE size;
    } memCtlT;

    typedef struct packed {
        aluOpE  aluOp;
        logic   alterCc;                        // cc variant, writes icc
        logic   rfEnable;
        memCtlT memCtl;
        wbSelE  wbSel;
        regIdxT rd;
    } decodedT;

    typedef struct packed {
        wordT instr;
        wordT opA;
        wordT opB;
    } issueT;

    typedef struct packed {
        wordT   result;                         // ALU output or memory address
        regIdxT rd;
        logic   rfEnable;
        memCtlT memCtl;
        wbSelE  wbSel;
    } resultT;

endpackage
